//--- Bender.yml
package:
  name: stu_cntl

sources:
  # packages first, then the receive chain and its top level
  - files:
      - common/stack_bus_pkg.sv
      - common/stu_cntl_pkg.sv
      - rtl/stu_input_fifo.sv
      - rtl/stu_prefetch_pipe.sv
      - stu_rx_fsm/stu_rx_fsm.sv
      - rtl/stu_output_regs.sv
      - rtl/stu_cntl.sv
  # testbench
  - target: simulation
    files:
      - verif/stu_cntl_tb.sv

//--- common/stack_bus_pkg.sv
/*
 * Upstream stack bus definitions shared by the receive chain.
 * Covers the beat framing code, the packet type and the bus field widths.
 * Import it wherever bus beats are declared or decoded.
 */

package stack_bus_pkg;

  // --------------------------------------------------
  // field widths
  // --------------------------------------------------
  localparam int DATA_W = 64;  // data word
  localparam int OOB_W  = 32;  // out-of-band word
  localparam int TAG_W  = 8;   // tag sits in oob[TAG_W-1:0]

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [OOB_W-1:0]  oob_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // --------------------------------------------------
  // framing, one code per beat
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CNTL_MOM     = 2'b00,  // middle of message
    CNTL_SOM     = 2'b01,  // first beat of a multi-beat packet
    CNTL_EOM     = 2'b10,  // last beat
    CNTL_SOM_EOM = 2'b11   // single beat packet
  } cntl_e;

  // packet type, only meaningful on the first beat
  typedef enum logic [2:0] {
    PKT_CONTROL         = 3'd0,
    PKT_TAG_ONLY        = 3'd1,  // not accepted by this receiver
    PKT_TAG_DATA_ONE    = 3'd2,
    PKT_TAG_DATA_TWO    = 3'd3,
    PKT_TAG_DATA_THREE  = 3'd4,
    PKT_TAG_DATA_FOUR   = 3'd5
  } pkt_type_e;

endpackage

//--- common/stu_cntl_pkg.sv
/*
 * Receiver-side sizing and state encoding for the upstream receive block.
 * FIFO sizes set the back-pressure point toward the sender.
 */

package stu_cntl_pkg;

  // --------------------------------------------------
  // input FIFO sizing
  // --------------------------------------------------
  localparam int FIFO_DEPTH     = 16;
  localparam int FIFO_THRESHOLD = 12;  // almost full at or above this
  localparam int FIFO_AW        = 4;   // pointer width, log2 of depth

  // four spare entries cover the beats still in flight
  // while the registered ready falls

  // --------------------------------------------------
  // receive FSM
  // --------------------------------------------------
  typedef enum logic [2:0] {
    RX_WAIT      = 3'd0,  // idle after reset
    RX_CTRL_SOM  = 3'd1,  // control packet opened
    RX_CTRL_MOM  = 3'd2,
    RX_CTRL_DONE = 3'd3,  // control packet closed
    RX_DATA_SOM  = 3'd4,  // data packet opened
    RX_DATA_MOM  = 3'd5,
    RX_DATA_DONE = 3'd6,  // data packet closed
    RX_ERR       = 3'd7   // framing error, held until reset
  } rx_state_e;

endpackage

//--- rtl/stu_cntl.sv
/*
 * Upstream receive side of the stack bus manager.
 * Input FIFO, prefetch pipe, routing FSM and registered rdp and rcp ports.
 */

`timescale 1ns/10ps

module stu_cntl (
  input  logic                     clk,
  input  logic                     arst_n,
  // upstream stack bus
  input  logic                     up_valid,
  input  stack_bus_pkg::cntl_e     up_cntl,
  input  stack_bus_pkg::pkt_type_e up_type,
  input  stack_bus_pkg::data_t     up_data,
  input  stack_bus_pkg::oob_t      up_oob_data,
  output logic                     up_ready,
  // return data processor
  output logic                     rdp_valid,
  output stack_bus_pkg::cntl_e     rdp_cntl,
  output stack_bus_pkg::tag_t      rdp_tag,
  output stack_bus_pkg::data_t     rdp_data,
  input  logic                     rdp_ready,
  // return control processor
  output logic                     rcp_valid,
  output stack_bus_pkg::cntl_e     rcp_cntl,
  output stack_bus_pkg::tag_t      rcp_tag,
  output stack_bus_pkg::data_t     rcp_data,
  input  logic                     rcp_ready,
  // status
  output logic                     rx_error
);

  import stack_bus_pkg::*;

  // --------------------------------------------------
  // FIFO to pipe
  // --------------------------------------------------
  logic      fifo_valid;
  logic      fifo_read;
  cntl_e     fifo_cntl;
  pkt_type_e fifo_type;
  data_t     fifo_data;
  oob_t      fifo_oob;

  // pipe to FSM and output regs
  logic      pipe_valid;
  logic      pipe_read;
  cntl_e     pipe_cntl;
  pkt_type_e pipe_type;
  data_t     pipe_data;
  oob_t      pipe_oob;
  logic      route_rdp;
  logic      route_rcp;

  stu_input_fifo i_stu_input_fifo (
    .clk, .arst_n,
    .up_valid, .up_cntl, .up_type, .up_data, .up_oob_data, .up_ready,
    .fifo_read, .fifo_valid, .fifo_cntl, .fifo_type, .fifo_data, .fifo_oob
  );

  stu_prefetch_pipe i_stu_prefetch_pipe (
    .clk, .arst_n,
    .fifo_valid, .fifo_cntl, .fifo_type, .fifo_data, .fifo_oob, .fifo_read,
    .pipe_read, .pipe_valid, .pipe_cntl, .pipe_type, .pipe_data, .pipe_oob
  );

  stu_rx_fsm i_stu_rx_fsm (
    .clk, .arst_n,
    .pipe_valid, .pipe_cntl, .pipe_type, .rdp_ready, .rcp_ready,
    .pipe_read, .route_rdp, .route_rcp, .rx_error
  );

  stu_output_regs i_stu_output_regs (
    .clk, .arst_n,
    .route_rdp, .route_rcp, .pipe_cntl, .pipe_data, .pipe_oob,
    .rdp_valid, .rdp_cntl, .rdp_tag, .rdp_data,
    .rcp_valid, .rcp_cntl, .rcp_tag, .rcp_data
  );

endmodule

//--- rtl/stu_input_fifo.sv
/*
 * Input stage of the upstream receiver.
 * Registers each incoming beat, writes it into a small FIFO and returns
 * a registered ready to the sender. Read data appears the cycle after fifo_read.
 */

`timescale 1ns/10ps

module stu_input_fifo (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     up_valid,
  input  stack_bus_pkg::cntl_e     up_cntl,
  input  stack_bus_pkg::pkt_type_e up_type,
  input  stack_bus_pkg::data_t     up_data,
  input  stack_bus_pkg::oob_t      up_oob_data,
  output logic                     up_ready,
  input  logic                     fifo_read,
  output logic                     fifo_valid,
  output stack_bus_pkg::cntl_e     fifo_cntl,
  output stack_bus_pkg::pkt_type_e fifo_type,
  output stack_bus_pkg::data_t     fifo_data,
  output stack_bus_pkg::oob_t      fifo_oob
);

  import stack_bus_pkg::*;
  import stu_cntl_pkg::*;

  logic                in_valid_q;  // doubles as write enable
  cntl_e               in_cntl_q;
  pkt_type_e           in_type_q;
  data_t               in_data_q;
  oob_t                in_oob_q;

  cntl_e               mem_cntl [FIFO_DEPTH];
  pkt_type_e           mem_type [FIFO_DEPTH];
  data_t               mem_data [FIFO_DEPTH];
  oob_t                mem_oob  [FIFO_DEPTH];

  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [FIFO_AW:0]    count;  // one extra bit to reach FIFO_DEPTH
  logic                almost_full;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      in_valid_q <= 1'b0;
    else
      in_valid_q <= up_valid;
  end

  always_ff @(posedge clk)
  begin
    if (up_valid)
    begin
      in_cntl_q <= up_cntl;
      in_type_q <= up_type;
      in_data_q <= up_data;
      in_oob_q  <= up_oob_data;
    end
  end

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (in_valid_q)
    begin
      mem_cntl[wr_ptr] <= in_cntl_q;
      mem_type[wr_ptr] <= in_type_q;
      mem_data[wr_ptr] <= in_data_q;
      mem_oob[wr_ptr]  <= in_oob_q;
    end
    if (fifo_read)  // registered read port
    begin
      fifo_cntl <= mem_cntl[rd_ptr];
      fifo_type <= mem_type[rd_ptr];
      fifo_data <= mem_data[rd_ptr];
      fifo_oob  <= mem_oob[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (in_valid_q)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (fifo_read)
        rd_ptr <= rd_ptr + 1'b1;
      case ({in_valid_q, fifo_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  assign fifo_valid  = (count != '0);
  assign almost_full = (count >= FIFO_THRESHOLD);

  // ready back to sender, one cycle behind the count
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      up_ready <= 1'b0;
    else
      up_ready <= ~almost_full;
  end

  // sender honours up_ready, so the spare entries never run out
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid_q |-> (count < FIFO_DEPTH) || fifo_read);

  // prefetch pipe only pops a non-empty FIFO
  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    fifo_read |-> fifo_valid);

endmodule

//--- rtl/stu_output_regs.sv
/*
 * Registered rdp and rcp output ports.
 * Captures the routed pipe beat with its tag and pulses that port's valid
 * for one cycle. A port's payload holds between beats.
 */

`timescale 1ns/10ps

module stu_output_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 route_rdp,
  input  logic                 route_rcp,
  input  stack_bus_pkg::cntl_e pipe_cntl,
  input  stack_bus_pkg::data_t pipe_data,
  input  stack_bus_pkg::oob_t  pipe_oob,
  output logic                 rdp_valid,
  output stack_bus_pkg::cntl_e rdp_cntl,
  output stack_bus_pkg::tag_t  rdp_tag,
  output stack_bus_pkg::data_t rdp_data,
  output logic                 rcp_valid,
  output stack_bus_pkg::cntl_e rcp_cntl,
  output stack_bus_pkg::tag_t  rcp_tag,
  output stack_bus_pkg::data_t rcp_data
);

  import stack_bus_pkg::*;

  tag_t beat_tag;

  assign beat_tag = pipe_oob[TAG_W-1:0];  // tag rides in low oob bits

  // --------------------------------------------------
  // valid strobes
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rdp_valid <= 1'b0;
      rcp_valid <= 1'b0;
    end
    else
    begin
      rdp_valid <= route_rdp;  // one cycle pulse per beat
      rcp_valid <= route_rcp;
    end
  end

  // payload, loads only for its own port
  always_ff @(posedge clk)
  begin
    if (route_rdp)
    begin
      rdp_cntl <= pipe_cntl;
      rdp_tag  <= beat_tag;
      rdp_data <= pipe_data;
    end
    if (route_rcp)
    begin
      rcp_cntl <= pipe_cntl;
      rcp_tag  <= beat_tag;
      rcp_data <= pipe_data;
    end
  end

endmodule

//--- rtl/stu_prefetch_pipe.sv
/*
 * Two-stage prefetch behind the input FIFO.
 * Stage one is the FIFO read register, stage two holds the beat the FSM sees.
 * Pops the FIFO whenever stage one is empty or moving on.
 */

`timescale 1ns/10ps

module stu_prefetch_pipe (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     fifo_valid,
  input  stack_bus_pkg::cntl_e     fifo_cntl,
  input  stack_bus_pkg::pkt_type_e fifo_type,
  input  stack_bus_pkg::data_t     fifo_data,
  input  stack_bus_pkg::oob_t      fifo_oob,
  output logic                     fifo_read,
  input  logic                     pipe_read,
  output logic                     pipe_valid,
  output stack_bus_pkg::cntl_e     pipe_cntl,
  output stack_bus_pkg::pkt_type_e pipe_type,
  output stack_bus_pkg::data_t     pipe_data,
  output stack_bus_pkg::oob_t      pipe_oob
);

  logic rd_stage_valid;  // FIFO read data holds a beat
  logic rd_stage_move;   // that beat moves into the payload stage

  assign rd_stage_move = rd_stage_valid & (~pipe_valid | pipe_read);
  assign fifo_read     = fifo_valid & (~rd_stage_valid | rd_stage_move);  // keep charged

  // --------------------------------------------------
  // stage valid flags
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_stage_valid <= 1'b0;
      pipe_valid     <= 1'b0;
    end
    else
    begin
      if (fifo_read)
        rd_stage_valid <= 1'b1;
      else if (rd_stage_move)
        rd_stage_valid <= 1'b0;  // drained, nothing behind it

      if (rd_stage_move)
        pipe_valid <= 1'b1;
      else if (pipe_read)
        pipe_valid <= 1'b0;
    end
  end

  // payload stage, loads only on a move
  always_ff @(posedge clk)
  begin
    if (rd_stage_move)
    begin
      pipe_cntl <= fifo_cntl;
      pipe_type <= fifo_type;
      pipe_data <= fifo_data;
      pipe_oob  <= fifo_oob;
    end
  end

  // FSM consumes only a beat that is present
  a_read_valid: assert property (@(posedge clk) disable iff (!arst_n)
    pipe_read |-> pipe_valid);

endmodule

//--- stu_rx_fsm/stu_rx_fsm.sv
/*
 * Packet classification and framing FSM of the upstream receiver.
 * Classifies each packet by its first beat, routes every beat to rcp or rdp
 * and latches a framing error until reset. Decisions are combinational.
 */

`timescale 1ns/10ps

module stu_rx_fsm (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     pipe_valid,
  input  stack_bus_pkg::cntl_e     pipe_cntl,
  input  stack_bus_pkg::pkt_type_e pipe_type,
  input  logic                     rdp_ready,
  input  logic                     rcp_ready,
  output logic                     pipe_read,
  output logic                     route_rdp,
  output logic                     route_rcp,
  output logic                     rx_error
);

  import stack_bus_pkg::*;
  import stu_cntl_pkg::*;

  rx_state_e state;
  rx_state_e state_d;
  logic      is_som;        // beat may open a packet
  logic      is_data_type;  // any tag and data type
  logic      to_rdp;        // destination of current beat
  logic      to_rcp;
  logic      beat_err;      // current beat breaks framing

  assign is_som       = (pipe_cntl == CNTL_SOM) || (pipe_cntl == CNTL_SOM_EOM);
  assign is_data_type = pipe_type inside {PKT_TAG_DATA_ONE, PKT_TAG_DATA_TWO,
                                          PKT_TAG_DATA_THREE, PKT_TAG_DATA_FOUR};

  // --------------------------------------------------
  // next state and destination
  // --------------------------------------------------
  always_comb
  begin
    state_d  = state;
    to_rdp   = 1'b0;
    to_rcp   = 1'b0;
    beat_err = 1'b0;
    case (state)
      RX_WAIT, RX_CTRL_DONE, RX_DATA_DONE:  // expecting a first beat
      begin
        if (is_som && (pipe_type == PKT_CONTROL))
        begin
          to_rcp  = 1'b1;
          state_d = (pipe_cntl == CNTL_SOM) ? RX_CTRL_SOM : RX_CTRL_DONE;
        end
        else if (is_som && is_data_type)
        begin
          to_rdp  = 1'b1;
          state_d = (pipe_cntl == CNTL_SOM) ? RX_DATA_SOM : RX_DATA_DONE;
        end
        else
          beat_err = 1'b1;  // tag only, or no start
      end
      RX_CTRL_SOM, RX_CTRL_MOM:
      begin
        to_rcp = 1'b1;  // type not rechecked mid packet
        case (pipe_cntl)
          CNTL_MOM: state_d = RX_CTRL_MOM;
          CNTL_EOM: state_d = RX_CTRL_DONE;
          default:  beat_err = 1'b1;  // new start inside a packet
        endcase
      end
      RX_DATA_SOM, RX_DATA_MOM:
      begin
        to_rdp = 1'b1;
        case (pipe_cntl)
          CNTL_MOM: state_d = RX_DATA_MOM;
          CNTL_EOM: state_d = RX_DATA_DONE;
          default:  beat_err = 1'b1;
        endcase
      end
      default: state_d = RX_ERR;  // RX_ERR sticks, reads stop
    endcase
    if (beat_err)
      state_d = RX_ERR;
  end

  // --------------------------------------------------
  // routing and consume
  // --------------------------------------------------
  // a beat leaves the pipe only when its port can take it
  assign route_rdp = pipe_valid & to_rdp & ~beat_err & rdp_ready;
  assign route_rcp = pipe_valid & to_rcp & ~beat_err & rcp_ready;

  // error beat is dropped regardless of ready
  assign pipe_read = route_rdp | route_rcp | (pipe_valid & beat_err);

  // state moves with the consumed beat
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= RX_WAIT;
    else if (pipe_read)
      state <= state_d;
  end

  assign rx_error = (state == RX_ERR);  // status level

  // one port per beat
  a_one_port: assert property (@(posedge clk) disable iff (!arst_n)
    !(route_rdp && route_rcp));

endmodule

//--- verif/stu_cntl_tb.sv
/*
 * Testbench for the upstream receive block.
 * Sends framed packets on the stack bus, predicts the port of every beat
 * and compares each rdp and rcp strobe against the expected queues.
 */

`timescale 1ns/10ps

module stu_cntl_tb;

  import stack_bus_pkg::*;

  localparam int PORT_NONE    = 0;  // beat is dropped
  localparam int PORT_RDP     = 1;
  localparam int PORT_RCP     = 2;
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;
  localparam int WAIT_LIMIT   = 4000;  // cycles per wait loop

  logic      clk = 1'b0;
  logic      arst_n;
  logic      up_valid;
  cntl_e     up_cntl;
  pkt_type_e up_type;
  data_t     up_data;
  oob_t      up_oob_data;
  logic      up_ready;
  logic      rdp_valid;
  cntl_e     rdp_cntl;
  tag_t      rdp_tag;
  data_t     rdp_data;
  logic      rdp_ready;
  logic      rcp_valid;
  cntl_e     rcp_cntl;
  tag_t      rcp_tag;
  data_t     rcp_data;
  logic      rcp_ready;
  logic      rx_error;

  int        seed = 17262;
  int        ready_mode = READY_HIGH;
  string     test_name = "reset";

  // expected beats, one set of queues per port
  cntl_e     exp_rdp_cntl[$];
  tag_t      exp_rdp_tag[$];
  data_t     exp_rdp_data[$];
  cntl_e     exp_rcp_cntl[$];
  tag_t      exp_rcp_tag[$];
  data_t     exp_rcp_data[$];

  stu_cntl i_stu_cntl (.*);

  always #20 clk = ~clk;  // 40 ns period

  // --------------------------------------------------
  // error handling and compare tasks
  // --------------------------------------------------
  task automatic fail_run(string reason);
    $display("%s (test %s)", reason, test_name);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_cntl(string what, cntl_e exp, cntl_e act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s expected %s actual %s", test_name, what, exp.name(), act.name());
      fail_run("framing code mismatch");
    end
  endtask

  task automatic check_tag(string what, tag_t exp, tag_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
      fail_run("tag mismatch");
    end
  endtask

  task automatic check_data(string what, data_t exp, data_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
      fail_run("data mismatch");
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s expected %b actual %b", test_name, what, exp, act);
      fail_run("status bit mismatch");
    end
  endtask

  // --------------------------------------------------
  // reference routing
  // --------------------------------------------------
  // port of a packet, from its first beat only
  function automatic int predict_port(pkt_type_e t, cntl_e first);
    if (!(first inside {CNTL_SOM, CNTL_SOM_EOM}))
      return PORT_NONE;  // no start, framing error
    if (t == PKT_CONTROL)
      return PORT_RCP;
    if (t inside {PKT_TAG_DATA_ONE, PKT_TAG_DATA_TWO, PKT_TAG_DATA_THREE, PKT_TAG_DATA_FOUR})
      return PORT_RDP;
    return PORT_NONE;  // tag only is refused
  endfunction

  // compare on the falling edge, outputs settled
  always @(negedge clk)
  begin
    if (arst_n && rdp_valid)
    begin
      if (exp_rdp_data.size() == 0)
        fail_run("a beat appeared on rdp when none was expected");
      check_cntl("rdp_cntl", exp_rdp_cntl.pop_front(), rdp_cntl);
      check_tag("rdp_tag", exp_rdp_tag.pop_front(), rdp_tag);
      check_data("rdp_data", exp_rdp_data.pop_front(), rdp_data);
    end
    if (arst_n && rcp_valid)
    begin
      if (exp_rcp_data.size() == 0)
        fail_run("a beat appeared on rcp when none was expected");
      check_cntl("rcp_cntl", exp_rcp_cntl.pop_front(), rcp_cntl);
      check_tag("rcp_tag", exp_rcp_tag.pop_front(), rcp_tag);
      check_data("rcp_data", exp_rcp_data.pop_front(), rcp_data);
    end
  end

  // downstream readies
  always @(posedge clk)
  begin
    case (ready_mode)
      READY_HIGH:
      begin
        rdp_ready <= 1'b1;
        rcp_ready <= 1'b1;
      end
      READY_RANDOM:
      begin
        rdp_ready <= 1'($random(seed));  // lsb only
        rcp_ready <= 1'($random(seed));
      end
      default:
      begin
        rdp_ready <= 1'b0;
        rcp_ready <= 1'b0;
      end
    endcase
  end

  // --------------------------------------------------
  // stimulus helpers, called on a rising edge
  // --------------------------------------------------
  task automatic send_beat(cntl_e c, pkt_type_e t, int port);
    data_t d;
    oob_t  o;
    int    waited;
    d      = {$random(seed), $random(seed)};
    o      = $random(seed);
    waited = 0;
    while (!up_ready)  // hold off while back-pressured
    begin
      up_valid <= 1'b0;
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        fail_run("up_ready stayed low while a beat was waiting");
    end
    up_valid    <= 1'b1;
    up_cntl     <= c;
    up_type     <= t;
    up_data     <= d;
    up_oob_data <= o;
    if (port == PORT_RDP)
    begin
      exp_rdp_cntl.push_back(c);
      exp_rdp_tag.push_back(o[TAG_W-1:0]);
      exp_rdp_data.push_back(d);
    end
    else if (port == PORT_RCP)
    begin
      exp_rcp_cntl.push_back(c);
      exp_rcp_tag.push_back(o[TAG_W-1:0]);
      exp_rcp_data.push_back(d);
    end
    @(posedge clk);
  endtask

  task automatic send_packet(pkt_type_e t, int len);
    cntl_e c;
    int    port;
    port = predict_port(t, (len == 1) ? CNTL_SOM_EOM : CNTL_SOM);
    for (int i = 0; i < len; i++)
    begin
      if (len == 1)
        c = CNTL_SOM_EOM;
      else if (i == 0)
        c = CNTL_SOM;
      else if (i == len - 1)
        c = CNTL_EOM;
      else
        c = CNTL_MOM;
      send_beat(c, t, port);  // type repeated on every beat
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((exp_rdp_data.size() != 0) || (exp_rcp_data.size() != 0))
    begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        fail_run("expected beats never arrived on the output ports");
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    int sent;
    int waited;
    arst_n      = 1'b0;
    up_valid    = 1'b0;
    up_cntl     = CNTL_MOM;
    up_type     = PKT_CONTROL;
    up_data     = '0;
    up_oob_data = '0;
    rdp_ready   = 1'b1;
    rcp_ready   = 1'b1;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // 1. quiet outputs, ready rises
    test_name = "reset";
    @(posedge clk);
    check_bit("rdp_valid", 1'b0, rdp_valid);
    check_bit("rcp_valid", 1'b0, rcp_valid);
    check_bit("rx_error", 1'b0, rx_error);
    waited = 0;
    while (!up_ready)
    begin
      @(posedge clk);
      waited++;
      if (waited > 4)
        fail_run("up_ready did not rise after reset");
    end

    // 2. single beat data packet
    test_name = "single_data";
    send_packet(PKT_TAG_DATA_TWO, 1);
    up_valid <= 1'b0;
    wait_drained();

    // 3. four beat control packet
    test_name = "control_four";
    send_packet(PKT_CONTROL, 4);
    up_valid <= 1'b0;
    wait_drained();

    // 4. random mix with toggling readies
    test_name  = "random_mix";
    ready_mode = READY_RANDOM;
    for (int n = 0; n < 200; n++)
    begin
      int k;
      k = $unsigned($random(seed)) % 5;  // control or one of four data types
      send_packet((k == 0) ? PKT_CONTROL : pkt_type_e'(k + 1), 1 + $unsigned($random(seed)) % 6);
    end
    up_valid <= 1'b0;
    ready_mode = READY_HIGH;
    wait_drained();
    check_bit("rx_error", 1'b0, rx_error);

    // 5. fill until back-pressure, then drain
    test_name  = "backpressure";
    ready_mode = READY_LOW;
    repeat (2) @(posedge clk);
    sent = 0;
    while (up_ready)
    begin
      send_packet((sent % 2) ? PKT_CONTROL : PKT_TAG_DATA_FOUR, 1);
      sent++;
      if (sent > WAIT_LIMIT)
        fail_run("up_ready never fell with both readies low");
    end
    up_valid <= 1'b0;
    ready_mode = READY_HIGH;
    wait_drained();
    check_bit("rx_error", 1'b0, rx_error);

    // 6. new start inside an open data packet
    test_name = "framing_error";
    send_beat(CNTL_SOM, PKT_TAG_DATA_ONE, PORT_RDP);
    send_beat(CNTL_MOM, PKT_TAG_DATA_ONE, PORT_RDP);
    send_beat(CNTL_SOM, PKT_TAG_DATA_ONE, PORT_NONE);  // consumed, not forwarded
    up_valid <= 1'b0;
    waited = 0;
    while (!rx_error)
    begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        fail_run("rx_error never rose after the bad start beat");
    end
    wait_drained();
    send_beat(CNTL_SOM_EOM, PKT_CONTROL, PORT_NONE);  // must stay stuck
    up_valid <= 1'b0;
    repeat (40) @(posedge clk);
    check_bit("rx_error", 1'b1, rx_error);

    if ((exp_rdp_data.size() != 0) || (exp_rcp_data.size() != 0))
      fail_run("expected beats left over at the end of the run");
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- verilog.f
common/stack_bus_pkg.sv
common/stu_cntl_pkg.sv
rtl/stu_input_fifo.sv
rtl/stu_prefetch_pipe.sv
stu_rx_fsm/stu_rx_fsm.sv
rtl/stu_output_regs.sv
rtl/stu_cntl.sv
verif/stu_cntl_tb.sv
